// File: verilog.f
+incdir+source
source/tcb_pkg.sv
source/tcb_logsize_ctrl.sv
source/tcb_req_steer.sv
source/tcb_rsp_steer.sv
source/tcb_mem_ben.sv
source/tcb_logsize_mem_top.sv
bench/tcb_logsize_tb.sv

// File: Bender.yml
package:
  name: tcb_logsize_mem

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/tcb_pkg.sv
      - source/tcb_logsize_ctrl.sv
      - source/tcb_req_steer.sv
      - source/tcb_rsp_steer.sv
      - source/tcb_mem_ben.sv
      - source/tcb_logsize_mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tcb_logsize_tb.sv

// File: bench/tcb_logsize_tb.sv
////////////////////////////////////////////////////////////
// directed testbench for the TCB log-size memory adapter
// byte-array reference model, access task, compare tasks
// reset, little/big endian, error and back-to-back tests
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tcb_defines.svh"

module tcb_logsize_tb;

  localparam int NBYTE = `TCB_MEM_WORDS * `TCB_BYTES;
  // cycles any single wait may take
  localparam int TMO = 20;

  logic              clk;
  logic              rst;
  logic              vld;
  logic              rdy;
  logic              rsp_vld;
  tcb_pkg::tcb_req_t req;
  tcb_pkg::tcb_rsp_t rsp;

  // reference memory with one entry per byte address
  logic [7:0] ref_mem [NBYTE];
  int mis_cnt;
  int tmo_cnt;
  int prt_cnt;

  tcb_logsize_mem_top dut (
    .clk     (clk),
    .rst     (rst),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // boundary crossing or size wider than the word
  function automatic logic is_err(tcb_pkg::tcb_req_t r);
    int off;
    off = r.adr % `TCB_BYTES;
    return (r.siz > `TCB_OFF_W) || ((off + (1 << r.siz)) > `TCB_BYTES);
  endfunction

  // byte address holding data byte i
  function automatic int lane_adr(tcb_pkg::tcb_req_t r, int i);
    int base;
    int off;
    int n;
    base = ((r.adr / `TCB_BYTES) % `TCB_MEM_WORDS) * `TCB_BYTES;
    off  = r.adr % `TCB_BYTES;
    n    = 1 << r.siz;
    if (r.ndn == tcb_pkg::tcb_big) begin
      return base + off + n - 1 - i;
    end
    return base + off + i;
  endfunction

  function automatic void ref_write(tcb_pkg::tcb_req_t r);
    if (!is_err(r)) begin
      for (int i = 0; i < (1 << r.siz); i++) begin
        ref_mem[lane_adr(r, i)] = r.wdt[i];
      end
    end
  endfunction

  // error gives sts set and zero data
  function automatic tcb_pkg::tcb_rsp_t ref_read(tcb_pkg::tcb_req_t r);
    tcb_pkg::tcb_rsp_t e;
    e = '0;
    if (is_err(r)) begin
      e.sts = 1'b1;
    end else begin
      for (int i = 0; i < (1 << r.siz); i++) begin
        e.rdt[i] = ref_mem[lane_adr(r, i)];
      end
    end
    return e;
  endfunction

  function automatic tcb_pkg::tcb_req_t make_req(logic wen, int adr, int siz,
                                                 tcb_pkg::tcb_ndn_t ndn,
                                                 tcb_pkg::tcb_dat_t wdt);
    tcb_pkg::tcb_req_t r;
    r.wen = wen;
    r.adr = adr;
    r.siz = siz;
    r.ndn = ndn;
    r.wdt = wdt;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_rsp(input string name, input tcb_pkg::tcb_rsp_t exp,
                           input tcb_pkg::tcb_rsp_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected rdt=%h sts=%b, actual rdt=%h sts=%b",
               name, exp.rdt, exp.sts, act.rdt, act.sts);
      mis_cnt++;
    end
  endtask

  task automatic check_sts(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected sts=%b, actual sts=%b", name, exp, act);
      mis_cnt++;
    end
  endtask

  task automatic check_dat(input string name, input tcb_pkg::tcb_dat_t exp,
                           input tcb_pkg::tcb_dat_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected lanes=%h, actual lanes=%h", name, exp, act);
      mis_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // access tasks
  ////////////////////////////////////////////////////////////

  // one request and its response one cycle after the transfer
  task automatic do_access(input string name, input tcb_pkg::tcb_req_t r,
                           output tcb_pkg::tcb_rsp_t got);
    int t;
    got = '0;
    @(negedge clk);
    vld = 1'b1;
    req = r;
    // rdy seen here holds through the next rising edge
    t = 0;
    while (!rdy && t < TMO) begin
      @(negedge clk);
      t++;
    end
    if (!rdy) begin
      $display("%s: timed out waiting for rdy", name);
      tmo_cnt++;
      vld = 1'b0;
      return;
    end
    @(negedge clk);
    vld = 1'b0;
    t = 1;
    while (!rsp_vld && t < TMO) begin
      @(negedge clk);
      t++;
    end
    if (!rsp_vld) begin
      $display("%s: timed out waiting for rsp_vld", name);
      tmo_cnt++;
    end else if (t != 1) begin
      $display("%s: response came %0d cycles after the transfer", name, t);
      prt_cnt++;
    end
    got = rsp;
  endtask

  // access plus check against the reference model
  task automatic access_check(input string name, input tcb_pkg::tcb_req_t r);
    tcb_pkg::tcb_rsp_t got;
    do_access(name, r, got);
    if (r.wen && !is_err(r)) begin
      check_sts(name, 1'b0, got.sts);
    end else begin
      check_rsp(name, ref_read(r), got);
    end
    if (r.wen) begin
      ref_write(r);
    end
  endtask

  // known value in every memory byte
  task automatic fill_mem();
    tcb_pkg::tcb_dat_t d;
    int a;
    for (int w = 0; w < `TCB_MEM_WORDS; w++) begin
      for (int l = 0; l < `TCB_BYTES; l++) begin
        a = w * `TCB_BYTES + l;
        d[l] = a[7:0] ^ (a[15:8] * 8'h3b) ^ 8'ha5;
      end
      access_check("fill", make_req(1'b1, w * `TCB_BYTES, 2, tcb_pkg::tcb_little, d));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int t;
    t = 0;
    while (!rdy && t < TMO) begin
      @(negedge clk);
      t++;
    end
    if (!rdy) begin
      $display("reset: timed out waiting for rdy after reset");
      tmo_cnt++;
    end
    // no response on an idle bus
    repeat (3) begin
      @(negedge clk);
      if (rsp_vld !== 1'b0) begin
        $display("reset: rsp_vld high without a transfer");
        prt_cnt++;
      end
    end
  endtask

  task automatic test_le_sizes();
    int w;
    for (int s = 0; s <= `TCB_OFF_W; s++) begin
      for (int o = 0; o + (1 << s) <= `TCB_BYTES; o++) begin
        w = 4 + s;
        access_check($sformatf("le_wr s%0d o%0d", s, o),
                     make_req(1'b1, w * `TCB_BYTES + o, s, tcb_pkg::tcb_little, $urandom));
        // untouched lanes keep their old bytes
        access_check($sformatf("le_rd s%0d o%0d", s, o),
                     make_req(1'b0, w * `TCB_BYTES, 2, tcb_pkg::tcb_little, '0));
      end
    end
  endtask

  task automatic test_be();
    tcb_pkg::tcb_dat_t v;
    tcb_pkg::tcb_dat_t swp;
    tcb_pkg::tcb_rsp_t exp;
    tcb_pkg::tcb_rsp_t got;
    int a;
    for (int s = 1; s <= 2; s++) begin
      for (int o = 0; o + (1 << s) <= `TCB_BYTES; o++) begin
        v = $urandom;
        a = 12 * `TCB_BYTES + o;
        access_check("be_wr", make_req(1'b1, a, s, tcb_pkg::tcb_big, v));
        // value comes back at the low bytes
        exp = '0;
        for (int i = 0; i < (1 << s); i++) begin
          exp.rdt[i] = v[i];
        end
        do_access("be_rd", make_req(1'b0, a, s, tcb_pkg::tcb_big, '0), got);
        check_rsp($sformatf("be_rd s%0d o%0d", s, o), exp, got);
        // whole word shows the big-endian lane order
        access_check($sformatf("be_word s%0d o%0d", s, o),
                     make_req(1'b0, 12 * `TCB_BYTES, 2, tcb_pkg::tcb_little, '0));
      end
    end
    // big-endian word puts its top byte on lane 0
    v = $urandom;
    for (int l = 0; l < `TCB_BYTES; l++) begin
      swp[l] = v[`TCB_BYTES - 1 - l];
    end
    access_check("be_word_wr", make_req(1'b1, 13 * `TCB_BYTES, 2, tcb_pkg::tcb_big, v));
    do_access("be_lanes", make_req(1'b0, 13 * `TCB_BYTES, 2, tcb_pkg::tcb_little, '0), got);
    check_dat("be_lanes", swp, got.rdt);
  endtask

  task automatic test_errors();
    int s_tab [6] = '{1, 2, 2, 2, 3, 3};
    int o_tab [6] = '{3, 1, 2, 3, 0, 2};
    for (int k = 0; k < 6; k++) begin
      access_check($sformatf("err_wr s%0d o%0d", s_tab[k], o_tab[k]),
                   make_req(1'b1, 20 * `TCB_BYTES + o_tab[k], s_tab[k],
                            tcb_pkg::tcb_ndn_t'(k % 2), 32'hdead_beef));
      access_check($sformatf("err_rd s%0d o%0d", s_tab[k], o_tab[k]),
                   make_req(1'b0, 20 * `TCB_BYTES + o_tab[k], s_tab[k],
                            tcb_pkg::tcb_little, '0));
      // memory untouched by the failed write
      access_check("err_chk", make_req(1'b0, 20 * `TCB_BYTES, 2, tcb_pkg::tcb_little, '0));
    end
  endtask

  // one request per cycle with responses checked in order
  task automatic test_random(input int n);
    tcb_pkg::tcb_req_t r;
    tcb_pkg::tcb_rsp_t exp_q [$];
    logic              wok_q [$];
    tcb_pkg::tcb_rsp_t e;
    logic              wok;
    logic              sent;
    sent = 1'b0;
    for (int k = 0; k <= n; k++) begin
      @(negedge clk);
      if (rsp_vld !== sent) begin
        $display("Mismatch random cycle %0d: expected rsp_vld=%b, actual rsp_vld=%b",
                 k, sent, rsp_vld);
        prt_cnt++;
      end
      if (sent) begin
        e   = exp_q.pop_front();
        wok = wok_q.pop_front();
        if (wok) begin
          check_sts($sformatf("random #%0d", k - 1), 1'b0, rsp.sts);
        end else begin
          check_rsp($sformatf("random #%0d", k - 1), e, rsp);
        end
      end
      sent = 1'b0;
      vld  = 1'b0;
      if (k < n) begin
        r = make_req($urandom % 2, $urandom % (32 * `TCB_BYTES), $urandom % 4,
                     tcb_pkg::tcb_ndn_t'($urandom % 2), $urandom);
        if (rdy !== 1'b1) begin
          $display("random: rdy low during back-to-back requests");
          prt_cnt++;
        end else begin
          vld = 1'b1;
          req = r;
          sent = 1'b1;
          exp_q.push_back(ref_read(r));
          wok_q.push_back(r.wen && !is_err(r));
          if (r.wen) begin
            ref_write(r);
          end
        end
      end
    end
    vld = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hd809));
    mis_cnt = 0;
    tmo_cnt = 0;
    prt_cnt = 0;
    rst = 1'b1;
    vld = 1'b0;
    req = '0;
    repeat (2) begin
      @(negedge clk);
      if (rdy !== 1'b0 || rsp_vld !== 1'b0) begin
        $display("reset: rdy or rsp_vld high during reset");
        prt_cnt++;
      end
    end
    rst = 1'b0;
    test_reset();
    fill_mem();
    test_le_sizes();
    test_be();
    test_errors();
    test_random(400);
    $display("errors: %0d mismatch, %0d timeout, %0d protocol", mis_cnt, tmo_cnt, prt_cnt);
    if (mis_cnt + tmo_cnt + prt_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: source/tcb_logsize_mem_top.sv
////////////////////////////////////////////////////////////
// TCB log-size to byte-enable adapter with memory
// control, request steering, memory, response steering
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcb_logsize_mem_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output logic              rsp_vld,
  output tcb_pkg::tcb_rsp_t rsp
);

  ////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////

  // transfer strobe
  logic                  trn;
  // current request error
  logic                  err;
  // response stage fields
  tcb_pkg::tcb_dly_t     dly;
  // memory side request
  tcb_pkg::tcb_ben_req_t man;
  // raw lanes from memory
  tcb_pkg::tcb_dat_t     rdt_lane;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  tcb_logsize_ctrl u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .trn     (trn),
    .err     (err),
    .dly     (dly),
    .rsp_vld (rsp_vld)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  tcb_req_steer u_req_steer (
    .req (req),
    .err (err),
    .man (man)
  );

  tcb_mem_ben u_mem (
    .clk      (clk),
    .trn      (trn),
    .man      (man),
    .rdt_lane (rdt_lane)
  );

  tcb_rsp_steer u_rsp_steer (
    .dly      (dly),
    .rdt_lane (rdt_lane),
    .rsp      (rsp)
  );

endmodule

// File: source/tcb_mem_ben.sv
////////////////////////////////////////////////////////////
// TCB byte-enable memory
// per-lane write enables, registered read of one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tcb_defines.svh"

module tcb_mem_ben (
  input  logic                  clk,
  input  logic                  trn,
  input  tcb_pkg::tcb_ben_req_t man,
  output tcb_pkg::tcb_dat_t     rdt_lane
);

  // word address bits actually decoded
  localparam int MEM_AW = $clog2(`TCB_MEM_WORDS);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  tcb_pkg::tcb_dat_t mem [`TCB_MEM_WORDS];

  // addressed word
  logic [MEM_AW-1:0] adr;

  // upper index bits fold onto the array
  assign adr = man.idx[MEM_AW-1:0];

  ////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////

  // only enabled lanes change, the rest keep old bytes
  always_ff @(posedge clk) begin
    if (trn && man.wen) begin
      for (int l = 0; l < `TCB_BYTES; l++) begin
        if (man.ben[l]) begin
          mem[adr][l] <= man.wdt[l];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////

  // full word on every transfer
  // a write returns the word as it was before the edge
  always_ff @(posedge clk) begin
    if (trn) begin
      rdt_lane <= mem[adr];
    end
  end

endmodule

// File: source/tcb_rsp_steer.sv
////////////////////////////////////////////////////////////
// TCB response steering
// read lanes back to low bytes, status from delayed error
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tcb_defines.svh"

module tcb_rsp_steer (
  input  tcb_pkg::tcb_dly_t dly,
  input  tcb_pkg::tcb_dat_t rdt_lane,
  output tcb_pkg::tcb_rsp_t rsp
);

  // lane feeding each response byte
  logic [`TCB_BYTES-1:0][`TCB_OFF_W-1:0] src;
  // response bytes kept
  logic [`TCB_BYTES-1:0] keep;

  ////////////////////////////////////////////////////////////
  // lane mapping, delayed offset and endianness
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [31:0] tmp;
    logic [31:0] lst;
    lst = (1 << dly.siz) - 1;
    for (int i = 0; i < `TCB_BYTES; i++) begin
      if (dly.ndn == tcb_pkg::tcb_big) begin
        tmp = dly.off + lst + `TCB_BYTES - i;
      end else begin
        tmp = dly.off + i;
      end
      src[i] = tmp[`TCB_OFF_W-1:0];
      // bytes at or above n read as zero, all of them on error
      keep[i] = (i < (1 << dly.siz)) & ~dly.err;
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `TCB_BYTES; i++) begin
      rsp.rdt[i] = keep[i] ? rdt_lane[src[i]] : 8'h00;
    end
  end

  assign rsp.sts = dly.err;

endmodule

// File: source/tcb_req_steer.sv
////////////////////////////////////////////////////////////
// TCB request steering
// byte-enable mask from size code, write data lane rotation
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tcb_defines.svh"

module tcb_req_steer (
  input  tcb_pkg::tcb_req_t     req,
  input  logic                  err,
  output tcb_pkg::tcb_ben_req_t man
);

  // word offset of the first byte
  logic [`TCB_OFF_W-1:0] off;
  // low-byte mask before rotation
  logic [`TCB_BYTES-1:0] msk;
  // data byte feeding each lane
  logic [`TCB_BYTES-1:0][`TCB_OFF_W-1:0] src;

  assign off = req.adr[`TCB_OFF_W-1:0];

  ////////////////////////////////////////////////////////////
  // mask and lane mapping
  ////////////////////////////////////////////////////////////

  // bytes 0 .. n-1 enabled
  always_comb begin
    for (int i = 0; i < `TCB_BYTES; i++) begin
      msk[i] = i < (1 << req.siz);
    end
  end

  // inverse of the lane rule, lane -> data byte
  // modulo by truncation, the word is a power of two
  always_comb begin
    logic [31:0] tmp;
    logic [31:0] lst;
    lst = (1 << req.siz) - 1;
    for (int l = 0; l < `TCB_BYTES; l++) begin
      if (req.ndn == tcb_pkg::tcb_big) begin
        // byte i on lane off+n-1-i
        tmp = off + lst + `TCB_BYTES - l;
      end else begin
        // byte i on lane off+i
        tmp = l + `TCB_BYTES - off;
      end
      src[l] = tmp[`TCB_OFF_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // memory side request
  ////////////////////////////////////////////////////////////

  assign man.wen = req.wen;
  assign man.idx = req.adr[`TCB_ADR_W-1:`TCB_OFF_W];

  always_comb begin
    for (int l = 0; l < `TCB_BYTES; l++) begin
      // rotated mask, nothing written on error
      man.ben[l] = msk[src[l]] & ~err;
      man.wdt[l] = req.wdt[src[l]];
    end
  end

endmodule

// File: source/tcb_logsize_ctrl.sv
////////////////////////////////////////////////////////////
// TCB log-size control
// handshake, size/boundary error check, response stage
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "tcb_defines.svh"

module tcb_logsize_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               vld,
  input  tcb_pkg::tcb_req_t  req,
  output logic               rdy,
  output logic               trn,
  output logic               err,
  output tcb_pkg::tcb_dly_t  dly,
  output logic               rsp_vld
);

  // byte offset inside the word
  logic [`TCB_OFF_W-1:0] off;
  // bytes in the access
  int unsigned           cnt;
  // error sources
  logic                  siz_err;
  logic                  bnd_err;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // no internal stall, ready once out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  assign trn = vld & rdy;

  ////////////////////////////////////////////////////////////
  // error judgement
  ////////////////////////////////////////////////////////////

  assign off = req.adr[`TCB_OFF_W-1:0];

  always_comb begin
    cnt = 1 << req.siz;
    // size code wider than the word
    siz_err = req.siz > `TCB_OFF_W;
    // last byte past the word end
    bnd_err = (off + cnt) > `TCB_BYTES;
  end

  assign err = siz_err | bnd_err;

  ////////////////////////////////////////////////////////////
  // response stage
  ////////////////////////////////////////////////////////////

  // captured on transfer, read by the response steering
  always_ff @(posedge clk) begin
    if (trn) begin
      dly.off <= off;
      dly.siz <= req.siz;
      dly.ndn <= req.ndn;
      dly.err <= err;
    end
  end

  // fixed delay of one cycle, no back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn;
    end
  end

endmodule

// File: source/tcb_pkg.sv
////////////////////////////////////////////////////////////
// TCB log-size adapter types
// size code, endianness, log-size request, byte-enable
// request, response and delayed request fields
////////////////////////////////////////////////////////////

`include "tcb_defines.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // basic fields
  ////////////////////////////////////////////////////////////

  // size code: 0/1/2 -> 1/2/4 bytes
  typedef logic [1:0] tcb_siz_t;

  // byte order of a multi-byte access
  typedef enum logic {
    tcb_little = 1'b0,
    tcb_big    = 1'b1
  } tcb_ndn_t;

  // one data word as byte lanes
  typedef logic [`TCB_BYTES-1:0][7:0] tcb_dat_t;

  ////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////

  // manager side, data packed at low bytes
  typedef struct packed {
    logic                  wen;
    logic [`TCB_ADR_W-1:0] adr;
    tcb_siz_t              siz;
    tcb_ndn_t              ndn;
    tcb_dat_t              wdt;
  } tcb_req_t;

  // memory side, data already on its lanes
  typedef struct packed {
    logic                             wen;
    logic [`TCB_ADR_W-`TCB_OFF_W-1:0] idx;
    logic [`TCB_BYTES-1:0]            ben;
    tcb_dat_t                         wdt;
  } tcb_ben_req_t;

  // sts set on error
  typedef struct packed {
    tcb_dat_t rdt;
    logic     sts;
  } tcb_rsp_t;

  // request fields carried into the response stage
  typedef struct packed {
    logic [`TCB_OFF_W-1:0] off;
    tcb_siz_t              siz;
    tcb_ndn_t              ndn;
    logic                  err;
  } tcb_dly_t;

endpackage

// File: source/tcb_defines.svh
////////////////////////////////////////////////////////////
// TCB log-size adapter shared parameters
// address width, data bytes, offset width, memory depth
////////////////////////////////////////////////////////////

`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////

// byte address width
`define TCB_ADR_W 12

// data bytes per word, power of two
`define TCB_BYTES 4

// byte offset bits inside a word
`define TCB_OFF_W $clog2(`TCB_BYTES)

////////////////////////////////////////////////////////////
// memory
////////////////////////////////////////////////////////////

// depth in words
`define TCB_MEM_WORDS 256

`endif
